// File: flist.f
hw/rv_exec_pkg.sv
hw/alu_result_if.sv
hw/flow_result_if.sv
hw/alu_path.sv
hw/flow_path.sv
hw/writeback_merge.sv
hw/exec_unit.sv
bench/exec_unit_assertions.sv
bench/exec_unit_tb.sv

// File: Makefile
SRCS := $(filter %.sv,$(shell cat flist.f))

obj_dir/Vexec_unit_tb: flist.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module exec_unit_tb -f flist.f

run: obj_dir/Vexec_unit_tb
	./obj_dir/Vexec_unit_tb

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: bench/exec_unit_tb.sv
`timescale 1ns/100ps

module exec_unit_tb;

    localparam int clk_half   = 2;
    localparam int wait_limit = 4;
    localparam int rand_count = 40;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] pc;
        logic        we;
        logic [31:0] data;
        logic        redir;
        logic [31:0] rpc;
        logic        ill;
    } row_t;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    rv_exec_pkg::instr_t    instr;
    rv_exec_pkg::word_t     rs1_val;
    rv_exec_pkg::word_t     rs2_val;
    rv_exec_pkg::word_t     pc;
    logic                   out_valid;
    logic                   rd_we;
    rv_exec_pkg::reg_addr_t rd_addr;
    rv_exec_pkg::word_t     rd_data;
    logic                   redirect;
    rv_exec_pkg::word_t     redirect_pc;
    logic                   illegal;

    row_t       rows [$];
    logic [2:0] f3_list [7] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd1, 3'd5};  // add sub first

    exec_unit uut (.*);

    always #clk_half clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error %s got %h expected %h", name, got, exp);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_flags_low();
        check_val("out_valid", 32'(out_valid), 32'd0);
        check_val("rd_we", 32'(rd_we), 32'd0);
        check_val("redirect", 32'(redirect), 32'd0);
        check_val("illegal", 32'(illegal), 32'd0);
    endtask

    task automatic add_row(input logic [31:0] i, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] p, input logic we, input logic [31:0] d,
                           input logic redir, input logic [31:0] rpc, input logic ill);
        rows.push_back({i, a, b, p, we, d, redir, rpc, ill});
    endtask

    task automatic apply_row(input row_t r);
        instr    = r.instr;
        rs1_val  = r.rs1;
        rs2_val  = r.rs2;
        pc       = r.pc;
        in_valid = 1'b1;
    endtask

    // Stops on the first falling edge that shows a result
    task automatic wait_result();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!out_valid && cycles < wait_limit);
        assert (out_valid) else begin
            $display("timeout: out_valid never came within %0d cycles", cycles);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    endtask

    task automatic check_row(input row_t r);
        check_val("rd_we", 32'(rd_we), 32'(r.we));
        check_val("redirect", 32'(redirect), 32'(r.redir));
        check_val("illegal", 32'(illegal), 32'(r.ill));
        if (r.we) begin
            check_val("rd_addr", 32'(rd_addr), 32'(r.instr[11:7]));
            check_val("rd_data", rd_data, r.data);
        end
        if (r.redir)
            check_val("redirect_pc", redirect_pc, r.rpc);
    endtask

    // Register ALU results by funct3, funct7 bit 5 picks SUB
    function automatic logic [31:0] ref_op(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    ref_op = (f7 == 7'h20) ? a - b : a + b;
            3'd1:    ref_op = a << b[4:0];
            3'd4:    ref_op = a ^ b;
            3'd5:    ref_op = a >> b[4:0];
            3'd6:    ref_op = a | b;
            default: ref_op = a & b;
        endcase
    endfunction

    function automatic row_t make_op_row(input int k, input logic [31:0] a,
                                         input logic [31:0] b, input logic [31:0] p);
        row_t       r;
        logic [6:0] f7;
        f7 = (k == 1) ? 7'h20 : 7'h00;
        r = {{f7, 5'd2, 5'd1, f3_list[k], 5'd5, 7'b0110011}, a, b, p,
             1'b1, ref_op(f7, f3_list[k], a, b), 1'b0, 32'd0, 1'b0};
        return r;
    endfunction

    initial begin
        row_t r;
        int   k;
        void'($urandom(67));
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        instr    = '0;
        rs1_val  = '0;
        rs2_val  = '0;
        pc       = '0;

        // ----------------------------------------------------------------
        // Directed table
        // ----------------------------------------------------------------
        add_row(32'hFFD08293, 32'd10, 32'd0, 32'h100, 1, 32'd7, 0, 32'h0, 0);    // addi -3
        add_row(32'h12345337, 32'd0, 32'd0, 32'h100, 1, 32'h12345000, 0, 32'h0, 0);
        add_row(32'hFFFFF397, 32'd0, 32'd0, 32'h100, 1, 32'hFFFFF100, 0, 32'h0, 0);
        add_row(32'h00208863, 32'd5, 32'd5, 32'h100, 0, 32'h0, 1, 32'h110, 0);   // beq
        add_row(32'h00208863, 32'd5, 32'd6, 32'h100, 0, 32'h0, 0, 32'h0, 0);
        add_row(32'h00209863, 32'd5, 32'd5, 32'h100, 0, 32'h0, 0, 32'h0, 0);
        add_row(32'h00209863, 32'd5, 32'd6, 32'h100, 0, 32'h0, 1, 32'h110, 0);
        add_row(32'hFE20CCE3, 32'hFFFFFFFF, 32'd1, 32'h200, 0, 32'h0, 1, 32'h1F8, 0);
        add_row(32'hFE20CCE3, 32'd1, 32'hFFFFFFFF, 32'h200, 0, 32'h0, 0, 32'h0, 0);
        add_row(32'h0020D863, 32'hFFFFFFFF, 32'd1, 32'h100, 0, 32'h0, 0, 32'h0, 0);
        add_row(32'h0020D863, 32'h7FFFFFFF, 32'h80000000, 32'h100, 0, 32'h0, 1, 32'h110, 0);
        add_row(32'h0020E863, 32'hFFFFFFFF, 32'd1, 32'h100, 0, 32'h0, 0, 32'h0, 0);
        add_row(32'h0020E863, 32'd1, 32'h80000000, 32'h100, 0, 32'h0, 1, 32'h110, 0);
        add_row(32'h0020F863, 32'hFFFFFFFF, 32'd1, 32'h100, 0, 32'h0, 1, 32'h110, 0);
        add_row(32'h0020F863, 32'd1, 32'hFFFFFFFF, 32'h100, 0, 32'h0, 0, 32'h0, 0);
        add_row(32'h020000EF, 32'd0, 32'd0, 32'h300, 1, 32'h304, 1, 32'h320, 0);  // jal x1
        add_row(32'h0200006F, 32'd0, 32'd0, 32'h300, 0, 32'h0, 1, 32'h320, 0);
        add_row(32'h005101E7, 32'h1000, 32'd0, 32'h400, 1, 32'h404, 1, 32'h1004, 0);
        add_row(32'h00510067, 32'h1000, 32'd0, 32'h400, 0, 32'h0, 1, 32'h1004, 0);
        add_row(32'h0000A283, 32'd0, 32'd0, 32'h100, 0, 32'h0, 0, 32'h0, 1);      // lw
        add_row(32'h022082B3, 32'd1, 32'd2, 32'h100, 0, 32'h0, 0, 32'h0, 1);
        add_row(32'h0020A863, 32'd5, 32'd5, 32'h100, 0, 32'h0, 0, 32'h0, 1);
        add_row(32'h00000000, 32'd0, 32'd0, 32'h100, 0, 32'h0, 0, 32'h0, 0);

        repeat (5) begin
            @(negedge clk);
            check_flags_low();
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_flags_low();

        foreach (rows[i]) begin
            apply_row(rows[i]);
            wait_result();
            check_row(rows[i]);
        end
        in_valid = 1'b0;
        @(negedge clk);
        check_flags_low();

        // Random OP operands, back to back, every op at least once
        for (int n = 0; n < rand_count; n++) begin
            k = (n < 7) ? n : int'($urandom % 7);
            r = make_op_row(k, $urandom, $urandom, $urandom);
            apply_row(r);
            wait_result();
            check_row(r);
        end
        in_valid = 1'b0;
        @(negedge clk);
        check_flags_low();

        $display("All tests passed");
        $finish;
    end

endmodule

// File: bench/exec_unit_assertions.sv
`timescale 1ns/100ps

module exec_unit_assertions (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic out_valid,
    input logic rd_we,
    input logic redirect,
    input logic illegal
);

    // Fixed latency of one cycle
    valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid))
        else $error("out_valid does not follow in_valid by one cycle");

    we_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        rd_we |-> out_valid)
        else $error("rd_we high without out_valid");

    redirect_legal: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> !illegal)
        else $error("redirect high on an illegal instruction");

    illegal_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        illegal |-> !rd_we)
        else $error("rd_we high on an illegal instruction");

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !out_valid && !rd_we && !redirect && !illegal)
        else $error("output flags not low during reset");

endmodule

bind exec_unit exec_unit_assertions u_checks (.*);

// File: hw/exec_unit.sv
`timescale 1ns/100ps

module exec_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  rv_exec_pkg::instr_t    instr,
    input  rv_exec_pkg::word_t     rs1_val,
    input  rv_exec_pkg::word_t     rs2_val,
    input  rv_exec_pkg::word_t     pc,
    output logic                   out_valid,
    output logic                   rd_we,
    output rv_exec_pkg::reg_addr_t rd_addr,
    output rv_exec_pkg::word_t     rd_data,
    output logic                   redirect,
    output rv_exec_pkg::word_t     redirect_pc,
    output logic                   illegal
);

    alu_result_if  alu_res ();
    flow_result_if flow_res ();

    // Both paths see every word, the merge keeps whichever claims it
    alu_path u_alu (
        .instr   (instr),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .pc      (pc),
        .res     (alu_res.src)
    );

    flow_path u_flow (
        .instr   (instr),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .pc      (pc),
        .res     (flow_res.src)
    );

    writeback_merge u_merge (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .instr       (instr),
        .alu         (alu_res.dst),
        .flow        (flow_res.dst),
        .out_valid   (out_valid),
        .rd_we       (rd_we),
        .redirect    (redirect),
        .illegal     (illegal),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .redirect_pc (redirect_pc)
    );

endmodule

// File: hw/writeback_merge.sv
`timescale 1ns/100ps

module writeback_merge (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  rv_exec_pkg::instr_t    instr,
    alu_result_if.dst              alu,
    flow_result_if.dst             flow,
    output logic                   out_valid,
    output logic                   rd_we,
    output logic                   redirect,
    output logic                   illegal,
    output rv_exec_pkg::reg_addr_t rd_addr,
    output rv_exec_pkg::word_t     rd_data,
    output rv_exec_pkg::word_t     redirect_pc
);

    logic               is_jump;
    logic               illegal_nxt;
    logic               rd_we_nxt;
    logic               redirect_nxt;
    rv_exec_pkg::word_t rd_data_nxt;

    // ----------------------------------------------------------------------
    // Result combine
    // ----------------------------------------------------------------------
    assign is_jump = flow.claim &&
                     ((instr.r_type.opcode == rv_exec_pkg::opc_jal) ||
                      (instr.r_type.opcode == rv_exec_pkg::opc_jalr));

    // Unclaimed non-zero word is illegal, zero word is a no-op
    assign illegal_nxt = alu.illegal || flow.illegal ||
                         (!alu.claim && !flow.claim && (instr != '0));

    assign rd_we_nxt    = (alu.wr_en || is_jump) && !illegal_nxt &&
                          (instr.r_type.rd != 5'd0);
    assign redirect_nxt = flow.claim && flow.taken && !illegal_nxt;
    assign rd_data_nxt  = is_jump ? flow.link_data : alu.wr_data;

    // ----------------------------------------------------------------------
    // Output register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            rd_we       <= 1'b0;
            redirect    <= 1'b0;
            illegal     <= 1'b0;
            rd_addr     <= '0;
            rd_data     <= '0;
            redirect_pc <= '0;
        end else begin
            out_valid <= in_valid;
            rd_we     <= in_valid && rd_we_nxt;      // flags last one cycle
            redirect  <= in_valid && redirect_nxt;
            illegal   <= in_valid && illegal_nxt;
            if (in_valid) begin
                rd_addr     <= instr.r_type.rd;
                rd_data     <= rd_data_nxt;
                redirect_pc <= flow.target;
            end
        end
    end

endmodule

// File: hw/flow_path.sv
`timescale 1ns/100ps

module flow_path (
    input  rv_exec_pkg::instr_t instr,
    input  rv_exec_pkg::word_t  rs1_val,
    input  rv_exec_pkg::word_t  rs2_val,
    input  rv_exec_pkg::word_t  pc,
    flow_result_if.src          res
);

    rv_exec_pkg::word_t imm_i;
    rv_exec_pkg::word_t imm_b;
    rv_exec_pkg::word_t imm_j;
    rv_exec_pkg::word_t jalr_sum;
    logic               eq;
    logic               lt_s;
    logic               lt_u;

    assign imm_i = {{20{instr.i_type.imm12[11]}}, instr.i_type.imm12};
    assign imm_b = {{19{instr.b_type.imm12}}, instr.b_type.imm12, instr.b_type.imm11,
                    instr.b_type.imm10_5, instr.b_type.imm4_1, 1'b0};
    assign imm_j = {{11{instr.j_type.imm20}}, instr.j_type.imm20, instr.j_type.imm19_12,
                    instr.j_type.imm11, instr.j_type.imm10_1, 1'b0};

    assign jalr_sum = rs1_val + imm_i;

    // Comparators shared by all six branches
    assign eq   = (rs1_val == rs2_val);
    assign lt_s = ($signed(rs1_val) < $signed(rs2_val));
    assign lt_u = (rs1_val < rs2_val);

    assign res.link_data = pc + 32'd4;

    always_comb begin
        res.claim   = 1'b0;
        res.illegal = 1'b0;
        res.taken   = 1'b0;
        res.target  = pc + imm_b;
        case (instr.r_type.opcode)
            rv_exec_pkg::opc_branch: begin
                res.claim = 1'b1;
                case (instr.b_type.funct3)
                    rv_exec_pkg::f3_beq:  res.taken = eq;
                    rv_exec_pkg::f3_bne:  res.taken = !eq;
                    rv_exec_pkg::f3_blt:  res.taken = lt_s;
                    rv_exec_pkg::f3_bge:  res.taken = !lt_s;
                    rv_exec_pkg::f3_bltu: res.taken = lt_u;
                    rv_exec_pkg::f3_bgeu: res.taken = !lt_u;
                    default:              res.illegal = 1'b1;
                endcase
            end
            rv_exec_pkg::opc_jal: begin
                res.claim  = 1'b1;
                res.taken  = 1'b1;
                res.target = pc + imm_j;
            end
            rv_exec_pkg::opc_jalr: begin
                res.claim   = 1'b1;
                res.taken   = 1'b1;
                res.target  = {jalr_sum[31:1], 1'b0};
                res.illegal = (instr.i_type.funct3 != 3'b000);
            end
            default: ;
        endcase
    end

endmodule

// File: hw/alu_path.sv
`timescale 1ns/100ps

module alu_path (
    input  rv_exec_pkg::instr_t instr,
    input  rv_exec_pkg::word_t  rs1_val,
    input  rv_exec_pkg::word_t  rs2_val,
    input  rv_exec_pkg::word_t  pc,
    alu_result_if.src           res
);

    rv_exec_pkg::word_t   imm_i;
    rv_exec_pkg::word_t   imm_u;
    rv_exec_pkg::word_t   op_b;
    rv_exec_pkg::word_t   alu_out;
    rv_exec_pkg::alu_op_t alu_op;
    logic                 is_op;
    logic                 bad_funct;

    assign imm_i = {{20{instr.i_type.imm12[11]}}, instr.i_type.imm12};
    assign imm_u = {instr.u_type.imm20, 12'b0};
    assign is_op = (instr.r_type.opcode == rv_exec_pkg::opc_op);
    assign op_b  = is_op ? rs2_val : imm_i;   // OP-IMM takes I immediate

    // OP decode, OP-IMM always adds
    always_comb begin
        alu_op    = rv_exec_pkg::alu_add;
        bad_funct = 1'b0;
        if (is_op) begin
            case (instr.r_type.funct3)
                3'b000: begin
                    if (instr.r_type.funct7 == 7'h20)
                        alu_op = rv_exec_pkg::alu_sub;
                    else if (instr.r_type.funct7 != 7'h00)
                        bad_funct = 1'b1;
                end
                3'b111: alu_op = rv_exec_pkg::alu_and;
                3'b110: alu_op = rv_exec_pkg::alu_or;
                3'b100: alu_op = rv_exec_pkg::alu_xor;
                3'b001: alu_op = rv_exec_pkg::alu_sll;
                3'b101: begin
                    if (instr.r_type.funct7 == 7'h00)
                        alu_op = rv_exec_pkg::alu_srl;
                    else
                        bad_funct = 1'b1;         // SRA not kept
                end
                default: bad_funct = 1'b1;        // SLT, SLTU
            endcase
        end
    end

    always_comb begin
        case (alu_op)
            rv_exec_pkg::alu_add: alu_out = rs1_val + op_b;
            rv_exec_pkg::alu_sub: alu_out = rs1_val - op_b;
            rv_exec_pkg::alu_and: alu_out = rs1_val & op_b;
            rv_exec_pkg::alu_or:  alu_out = rs1_val | op_b;
            rv_exec_pkg::alu_xor: alu_out = rs1_val ^ op_b;
            rv_exec_pkg::alu_sll: alu_out = rs1_val << op_b[4:0];
            rv_exec_pkg::alu_srl: alu_out = rs1_val >> op_b[4:0];
            default:              alu_out = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // Claim and write data
    // ----------------------------------------------------------------------
    always_comb begin
        res.claim   = 1'b1;
        res.illegal = 1'b0;
        res.wr_en   = 1'b1;
        res.wr_data = alu_out;
        case (instr.r_type.opcode)
            rv_exec_pkg::opc_op:     res.illegal = bad_funct;
            rv_exec_pkg::opc_op_imm: ;                  // ALU sum as is
            rv_exec_pkg::opc_lui:    res.wr_data = imm_u;
            rv_exec_pkg::opc_auipc:  res.wr_data = pc + imm_u;
            default: begin
                res.claim = 1'b0;
                res.wr_en = 1'b0;
            end
        endcase
    end

endmodule

// File: hw/flow_result_if.sv
`timescale 1ns/100ps

interface flow_result_if;

    logic               claim;
    logic               illegal;
    logic               taken;
    rv_exec_pkg::word_t target;
    rv_exec_pkg::word_t link_data;   // pc+4 for JAL/JALR

    modport src (
        output claim,
        output illegal,
        output taken,
        output target,
        output link_data
    );

    modport dst (
        input claim,
        input illegal,
        input taken,
        input target,
        input link_data
    );

endinterface

// File: hw/alu_result_if.sv
`timescale 1ns/100ps

interface alu_result_if;

    logic               claim;
    logic               illegal;
    logic               wr_en;
    rv_exec_pkg::word_t wr_data;

    modport src (
        output claim,
        output illegal,
        output wr_en,
        output wr_data
    );

    modport dst (
        input claim,
        input illegal,
        input wr_en,
        input wr_data
    );

endinterface

// File: hw/rv_exec_pkg.sv
package rv_exec_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // ----------------------------------------------------------------------
    // Major opcodes
    // ----------------------------------------------------------------------
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;

    // Branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl
    } alu_op_t;

    // ----------------------------------------------------------------------
    // Instruction formats, msb first
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_type;
        i_fmt_t i_type;
        b_fmt_t b_type;
        u_fmt_t u_type;
        j_fmt_t j_type;
    } instr_t;

endpackage
